//--- project.f
logic/cpu_pkg.sv
logic/instr_decoder.sv
logic/sequencer.sv
logic/register_file.sv
logic/alu.sv
logic/datapath.sv
logic/cpu_core.sv
tests/cpu_core_properties.sv
tests/cpu_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_name=cpu_core_sim
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f project.f --top-module cpu_core_tb \
  -Mdir "$build_dir" -o "$sim_name"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$build_dir/$sim_name" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if [ $run_status -ne 0 ]; then
  echo "simulator exited with status $run_status"
  exit 1
fi

if grep -q "Simulation failed" "$log_file"; then
  exit 1
fi

if ! grep -q "Simulation passed" "$log_file"; then
  echo "no verdict found in $log_file"
  exit 1
fi

exit 0

//--- tests/cpu_core_tb.sv
`timescale 1ns/1ns

module cpu_core_tb;

  typedef struct packed {
    logic [15:0] instr;
    logic        chk_out;
    logic [15:0] exp_out;
    logic        chk_flags;
    logic        exp_z;
    logic        exp_n;
    logic        exp_v;
    logic [3:0]  exp_lat;     // cycles from accept to waiting
    logic        spur_en;     // extra strobe while busy
    logic [15:0] spur_instr;
  } row_t;

  logic        clk;
  logic        reset;
  logic [15:0] instr;
  logic        instr_valid;
  logic        waiting;
  logic [15:0] out;
  logic        z;
  logic        n;
  logic        v;

  row_t        rows[$];
  row_t        row;
  logic [15:0] model_regs [8];
  logic [15:0] model_c;
  logic        model_z;
  logic        model_n;
  logic        model_v;
  logic        spur_pending;
  logic [15:0] spur_word;
  logic [31:0] rnd;
  int          seed;
  int          errors;
  int          checks;
  int          errors_before;
  int          lows;
  int          cycle_count;
  int          cycle_limit;

  cpu_core i_dut (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .instr_valid (instr_valid),
    .waiting     (waiting),
    .out         (out),
    .z           (z),
    .n           (n),
    .v           (v)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [15:0] sext8(input logic [7:0] imm);
    return {{8{imm[7]}}, imm};
  endfunction

  function automatic logic [15:0] shift_value(input logic [15:0] val, input logic [1:0] sh);
    case (sh)
      2'd1: return val << 1;
      2'd2: return val >> 1;
      2'd3: return 16'($signed(val) >>> 1);  // sign bit kept
      default: return val;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic add_row(input logic [15:0] word, input logic chk_out, input logic chk_flags,
                         input logic [3:0] lat);
    row_t r;
    r.instr      = word;
    r.chk_out    = chk_out;
    r.exp_out    = model_c;
    r.chk_flags  = chk_flags;
    r.exp_z      = model_z;
    r.exp_n      = model_n;
    r.exp_v      = model_v;
    r.exp_lat    = lat;
    r.spur_en    = spur_pending;
    r.spur_instr = spur_word;
    spur_pending = 1'b0;
    rows.push_back(r);
  endtask

  task automatic load_imm(input logic [2:0] rn, input logic [7:0] imm);
    model_regs[rn] = sext8(imm);
    add_row({3'b110, 2'b10, rn, imm}, 1'b0, 1'b0, 4'd2);  // C untouched
  endtask

  task automatic copy_reg(input logic [2:0] rd, input logic [1:0] sh, input logic [2:0] rm);
    model_c = shift_value(model_regs[rm], sh);
    model_regs[rd] = model_c;
    add_row({3'b110, 2'b00, 3'b000, rd, sh, rm}, 1'b1, 1'b1, 4'd4);
  endtask

  task automatic read_reg(input logic [2:0] r);
    copy_reg(r, 2'd0, r);  // copy onto itself so it shows up on out
  endtask

  task automatic alu_row(input logic [1:0] op, input logic [2:0] rn, input logic [2:0] rd,
                         input logic [1:0] sh, input logic [2:0] rm);
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] diff;
    logic [3:0]  lat;
    a = model_regs[rn];
    b = shift_value(model_regs[rm], sh);
    lat = 4'd5;
    case (op)
      2'b00: model_c = a + b;
      2'b10: model_c = a & b;
      2'b11: begin
        model_c = ~b;
        lat = 4'd4;  // mvn skips loading A
      end
      default: begin
        diff = a - b;
        model_z = (diff == 16'd0);
        model_n = diff[15];
        model_v = (a[15] != b[15]) && (diff[15] != a[15]);
        lat = 4'd4;
      end
    endcase
    if (op != 2'b01) model_regs[rd] = model_c;
    add_row({3'b101, op, rn, rd, sh, rm}, 1'b1, 1'b1, lat);
  endtask

  task automatic build_table();
    for (int r = 0; r < 8; r++) begin
      load_imm(3'(r), 8'(8'h05 + r * 13));
      read_reg(3'(r));
      load_imm(3'(r), 8'(8'h80 + r * 9));
      read_reg(3'(r));
    end
    load_imm(3'd1, 8'hB5);
    for (int s = 0; s < 4; s++) begin
      copy_reg(3'd2, 2'(s), 3'd1);
    end
    read_reg(3'd2);
    load_imm(3'd1, 8'h4A);
    copy_reg(3'd3, 2'd3, 3'd1);  // arithmetic shift of a positive value
    for (int k = 0; k < 6; k++) begin
      rnd = $random(seed);
      load_imm(3'd4, rnd[7:0]);
      load_imm(3'd5, rnd[15:8]);
      alu_row(2'b00, 3'd4, 3'd6, rnd[17:16], 3'd5);
      alu_row(2'b10, 3'd4, 3'd7, rnd[19:18], 3'd5);
      alu_row(2'b11, 3'd0, 3'd6, rnd[21:20], 3'd6);
      alu_row(2'b00, 3'd6, 3'd6, 2'd1, 3'd7);
    end
    load_imm(3'd4, 8'h23);
    load_imm(3'd5, 8'h23);
    load_imm(3'd6, 8'h30);
    alu_row(2'b01, 3'd4, 3'd0, 2'd0, 3'd5);  // equal
    alu_row(2'b01, 3'd4, 3'd0, 2'd0, 3'd6);  // negative
    alu_row(2'b01, 3'd6, 3'd0, 2'd0, 3'd4);
    load_imm(3'd1, 8'h7F);
    load_imm(3'd2, 8'h81);
    for (int k = 0; k < 8; k++) begin
      alu_row(2'b00, 3'd1, 3'd1, 2'd0, 3'd1);  // doubles toward 7f00
      alu_row(2'b00, 3'd2, 3'd2, 2'd0, 3'd2);  // and toward 8100
    end
    alu_row(2'b01, 3'd1, 3'd0, 2'd0, 3'd2);  // signed overflow
    alu_row(2'b00, 3'd1, 3'd3, 2'd0, 3'd2);  // zero sum that leaves the flags alone
    load_imm(3'd3, 8'h11);
    spur_word = {3'b110, 2'b10, 3'd3, 8'h77};
    spur_pending = 1'b1;
    alu_row(2'b00, 3'd3, 3'd7, 2'd0, 3'd3);
    read_reg(3'd3);
    add_row(16'h0000, 1'b1, 1'b1, 4'd1);
    add_row(16'hFFFF, 1'b1, 1'b1, 4'd1);
    add_row(16'hC8E3, 1'b1, 1'b1, 4'd1);  // mov with op field 01
    read_reg(3'd3);
    read_reg(3'd7);
    read_reg(3'd0);  // Rn of the op 01 mov word
  endtask

  initial begin
    reset = 1'b1;
    instr = '0;
    instr_valid = 1'b0;
    seed = 98;
    errors = 0;
    checks = 0;
    model_c = '0;
    model_z = 1'b0;
    model_n = 1'b0;
    model_v = 1'b0;
    spur_pending = 1'b0;
    spur_word = '0;
    build_table();
    cycle_limit = rows.size() * 8 + 20;

    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);

    for (int i = 0; i < rows.size(); i++) begin
      row = rows[i];
      errors_before = errors;
      while (waiting !== 1'b1) @(negedge clk);
      @(posedge clk);
      instr <= row.instr;
      instr_valid <= 1'b1;
      @(posedge clk);  // accepting edge
      instr_valid <= 1'b0;
      lows = 0;
      @(negedge clk);
      while (waiting !== 1'b1) begin
        lows++;
        if (row.spur_en && lows <= 2) begin
          @(posedge clk);
          instr <= row.spur_instr;
          instr_valid <= (lows == 1);
        end
        @(negedge clk);
      end
      check_value("latency", 16'(lows), {12'd0, row.exp_lat});
      if (row.chk_out) check_value("out", out, row.exp_out);
      if (row.chk_flags) begin
        check_value("z", {15'd0, z}, {15'd0, row.exp_z});
        check_value("n", {15'd0, n}, {15'd0, row.exp_n});
        check_value("v", {15'd0, v}, {15'd0, row.exp_v});
      end
      $display("row %0d instr %h: %s", i, row.instr,
               (errors == errors_before) ? "ok" : "FAILED");
    end

    $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_limit == 0 || cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("run timed out after %0d cycles", cycle_count);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- tests/cpu_core_properties.sv
`timescale 1ns/1ns

module cpu_core_properties (
  input logic clk,
  input logic reset,
  input logic instr_valid,
  input logic waiting,
  input logic en_status,
  input logic z,
  input logic n,
  input logic v
);

  int unsigned low_cycles;  // consecutive samples with waiting low

  always_ff @(posedge clk) begin
    if (reset || waiting) begin
      low_cycles <= '0;
    end else begin
      low_cycles <= low_cycles + 1;
    end
  end

  assert property (@(posedge clk) $fell(reset) |-> waiting)
    else $error("waiting low right after reset");

  assert property (@(posedge clk) disable iff (reset) (instr_valid && waiting) |=> !waiting)
    else $error("accepted instruction did not drop waiting");

  // longest instruction keeps waiting low for 5 cycles
  assert property (@(posedge clk) disable iff (reset) !waiting |-> low_cycles < 5)
    else $error("waiting stayed low for more than 5 cycles");

  assert property (@(posedge clk) disable iff (reset) $past(en_status) || $stable({z, n, v}))
    else $error("flags changed without status enable");

endmodule

bind cpu_core cpu_core_properties i_properties (
  .clk         (clk),
  .reset       (reset),
  .instr_valid (instr_valid),
  .waiting     (waiting),
  .en_status   (en_status),
  .z           (z),
  .n           (n),
  .v           (v)
);

//--- logic/cpu_core.sv
`timescale 1ns/1ns

module cpu_core (
  input  logic           clk,
  input  logic           reset,
  input  cpu_pkg::word_t instr,
  input  logic           instr_valid,
  output logic           waiting,
  output cpu_pkg::word_t out,
  output logic           z,
  output logic           n,
  output logic           v
);
  import cpu_pkg::*;

  opcode_t   opcode;
  alu_op_t   alu_op;
  shift_op_t shift_op;
  word_t     imm8;
  reg_addr_t reg_addr;
  reg_sel_t  reg_sel;
  wb_sel_t   wb_sel;
  logic      load_ir;
  logic      w_en;
  logic      en_a;
  logic      en_b;
  logic      en_c;
  logic      en_status;
  logic      sel_a;

  instr_decoder i_instr_decoder (
    .clk      (clk),
    .instr    (instr),
    .load_ir  (load_ir),
    .reg_sel  (reg_sel),
    .opcode   (opcode),
    .alu_op   (alu_op),
    .shift_op (shift_op),
    .imm8     (imm8),
    .reg_addr (reg_addr)
  );

  sequencer i_sequencer (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .opcode      (opcode),
    .alu_op      (alu_op),
    .waiting     (waiting),
    .load_ir     (load_ir),
    .reg_sel     (reg_sel),
    .wb_sel      (wb_sel),
    .w_en        (w_en),
    .en_a        (en_a),
    .en_b        (en_b),
    .en_c        (en_c),
    .en_status   (en_status),
    .sel_a       (sel_a)
  );

  // mov register carries op field 00, so the ALU adds B to zero
  datapath i_datapath (
    .clk       (clk),
    .reset     (reset),
    .imm8      (imm8),
    .reg_addr  (reg_addr),
    .wb_sel    (wb_sel),
    .w_en      (w_en),
    .en_a      (en_a),
    .en_b      (en_b),
    .en_c      (en_c),
    .en_status (en_status),
    .sel_a     (sel_a),
    .shift_op  (shift_op),
    .alu_op    (alu_op),
    .out       (out),
    .z         (z),
    .n         (n),
    .v         (v)
  );

endmodule

//--- logic/datapath.sv
`timescale 1ns/1ns

module datapath (
  input  logic               clk,
  input  logic               reset,
  input  cpu_pkg::word_t     imm8,
  input  cpu_pkg::reg_addr_t reg_addr,
  input  cpu_pkg::wb_sel_t   wb_sel,
  input  logic               w_en,
  input  logic               en_a,
  input  logic               en_b,
  input  logic               en_c,
  input  logic               en_status,
  input  logic               sel_a,
  input  cpu_pkg::shift_op_t shift_op,
  input  cpu_pkg::alu_op_t   alu_op,
  output cpu_pkg::word_t     out,
  output logic               z,
  output logic               n,
  output logic               v
);
  import cpu_pkg::*;

  word_t      reg_a;
  word_t      reg_b;
  word_t      reg_c;
  logic [2:0] status;  // v n z
  word_t      r_data;
  word_t      w_data;
  word_t      b_shifted;
  word_t      alu_a;
  word_t      alu_result;
  logic       alu_z;
  logic       alu_n;
  logic       alu_v;

  assign w_data = (wb_sel == wb_imm) ? imm8 : reg_c;

  register_file i_register_file (
    .clk    (clk),
    .w_en   (w_en),
    .w_addr (reg_addr),
    .w_data (w_data),
    .r_addr (reg_addr),
    .r_data (r_data)
  );

  always_comb begin
    case (shift_op)
      sh_left:        b_shifted = {reg_b[word_width-2:0], 1'b0};
      sh_right_logic: b_shifted = {1'b0, reg_b[word_width-1:1]};
      sh_right_arith: b_shifted = {reg_b[word_width-1], reg_b[word_width-1:1]};
      default:        b_shifted = reg_b;
    endcase
  end

  assign alu_a = sel_a ? '0 : reg_a;  // zero for mov and mvn

  alu i_alu (
    .a      (alu_a),
    .b      (b_shifted),
    .alu_op (alu_op),
    .result (alu_result),
    .z      (alu_z),
    .n      (alu_n),
    .v      (alu_v)
  );

  always_ff @(posedge clk) begin
    if (en_a) reg_a <= r_data;
    if (en_b) reg_b <= r_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      reg_c  <= '0;
      status <= '0;
    end else begin
      if (en_c) reg_c <= alu_result;
      if (en_status) status <= {alu_v, alu_n, alu_z};
    end
  end

  assign out = reg_c;
  assign z   = status[0];
  assign n   = status[1];
  assign v   = status[2];

endmodule

//--- logic/alu.sv
`timescale 1ns/1ns

module alu (
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  input  cpu_pkg::alu_op_t alu_op,
  output cpu_pkg::word_t   result,
  output logic             z,
  output logic             n,
  output logic             v
);
  import cpu_pkg::*;

  logic  subtract;
  word_t b_eff;
  word_t sum;
  logic  overflow;

  assign subtract = (alu_op == alu_sub);
  assign b_eff    = subtract ? ~b : b;  // two's complement with carry in
  assign sum      = a + b_eff + word_t'(subtract);

  // operand signs agree, result sign differs
  assign overflow = (a[word_width-1] == b_eff[word_width-1]) &&
                    (sum[word_width-1] != a[word_width-1]);

  always_comb begin
    case (alu_op)
      alu_and: result = a & b;
      alu_not: result = ~b;
      default: result = sum;
    endcase
  end

  assign z = (result == '0);
  assign n = result[word_width-1];
  assign v = (alu_op == alu_add || alu_op == alu_sub) ? overflow : 1'b0;

endmodule

//--- logic/register_file.sv
`timescale 1ns/1ns

module register_file (
  input  logic               clk,
  input  logic               w_en,
  input  cpu_pkg::reg_addr_t w_addr,
  input  cpu_pkg::word_t     w_data,
  input  cpu_pkg::reg_addr_t r_addr,
  output cpu_pkg::word_t     r_data
);
  import cpu_pkg::*;

  word_t regs [reg_count];

  always_ff @(posedge clk) begin
    if (w_en) regs[w_addr] <= w_data;
  end

  assign r_data = regs[r_addr];  // async read

endmodule

//--- logic/sequencer.sv
`timescale 1ns/1ns

module sequencer (
  input  logic              clk,
  input  logic              reset,
  input  logic              instr_valid,
  input  cpu_pkg::opcode_t  opcode,
  input  cpu_pkg::alu_op_t  alu_op,
  output logic              waiting,
  output logic              load_ir,
  output cpu_pkg::reg_sel_t reg_sel,
  output cpu_pkg::wb_sel_t  wb_sel,
  output logic              w_en,
  output logic              en_a,
  output logic              en_b,
  output logic              en_c,
  output logic              en_status,
  output logic              sel_a
);
  import cpu_pkg::*;

  typedef enum logic [3:0] {
    s_idle,
    s_dispatch,
    s_write_imm,     // mov imm, write Rn
    s_load_a,
    s_load_b,
    s_compute_zero,  // mov reg and mvn, A forced to zero
    s_compute,
    s_write_rd,
    s_status         // cmp, flags only
  } state_t;

  state_t state;
  state_t state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      s_idle: begin
        if (instr_valid) state_next = s_dispatch;
      end
      s_dispatch: begin
        if (opcode == op_mov && alu_op == mov_imm_op) begin
          state_next = s_write_imm;
        end else if (opcode == op_mov && alu_op == mov_reg_op) begin
          state_next = s_load_b;
        end else if (opcode == op_alu && alu_op == alu_not) begin
          state_next = s_load_b;  // mvn needs only Rm
        end else if (opcode == op_alu) begin
          state_next = s_load_a;
        end else begin
          state_next = s_idle;  // unknown instruction, nothing changes
        end
      end
      s_load_a: state_next = s_load_b;
      s_load_b: begin
        if (opcode == op_alu && alu_op == alu_sub) begin
          state_next = s_status;
        end else if (opcode == op_mov || alu_op == alu_not) begin
          state_next = s_compute_zero;
        end else begin
          state_next = s_compute;
        end
      end
      s_compute_zero: state_next = s_write_rd;
      s_compute:      state_next = s_write_rd;
      default:        state_next = s_idle;  // write and status steps end here
    endcase
  end

  assign waiting = (state == s_idle);
  assign load_ir = (state == s_idle) && instr_valid;

  always_comb begin
    reg_sel   = sel_rm;
    wb_sel    = wb_result;
    w_en      = 1'b0;
    en_a      = 1'b0;
    en_b      = 1'b0;
    en_c      = 1'b0;
    en_status = 1'b0;
    sel_a     = 1'b0;
    case (state)
      s_write_imm: begin
        reg_sel = sel_rn;
        wb_sel  = wb_imm;
        w_en    = 1'b1;
      end
      s_load_a: begin
        reg_sel = sel_rn;
        en_a    = 1'b1;
      end
      s_load_b: begin
        reg_sel = sel_rm;
        en_b    = 1'b1;
      end
      s_compute_zero: begin
        sel_a = 1'b1;
        en_c  = 1'b1;
      end
      s_compute: en_c = 1'b1;
      s_write_rd: begin
        reg_sel = sel_rd;
        w_en    = 1'b1;  // C goes back to Rd
      end
      s_status: en_status = 1'b1;
      default: ;
    endcase
  end

endmodule

//--- logic/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
  input  logic               clk,
  input  cpu_pkg::word_t     instr,
  input  logic               load_ir,
  input  cpu_pkg::reg_sel_t  reg_sel,
  output cpu_pkg::opcode_t   opcode,
  output cpu_pkg::alu_op_t   alu_op,
  output cpu_pkg::shift_op_t shift_op,
  output cpu_pkg::word_t     imm8,
  output cpu_pkg::reg_addr_t reg_addr
);
  import cpu_pkg::*;

  word_t ir;

  always_ff @(posedge clk) begin
    if (load_ir) ir <= instr;  // held until the next accepted strobe
  end

  assign opcode   = opcode_t'(ir[opcode_msb:opcode_lsb]);
  assign alu_op   = alu_op_t'(ir[op_msb:op_lsb]);
  assign shift_op = shift_op_t'(ir[shift_msb:shift_lsb]);

  // sign extend the 8-bit immediate
  assign imm8 = {{(word_width - (imm8_msb - imm8_lsb + 1)){ir[imm8_msb]}},
                 ir[imm8_msb:imm8_lsb]};

  always_comb begin
    case (reg_sel)
      sel_rm:  reg_addr = ir[rm_msb:rm_lsb];
      sel_rd:  reg_addr = ir[rd_msb:rd_lsb];
      sel_rn:  reg_addr = ir[rn_msb:rn_lsb];
      default: reg_addr = '0;  // unused code points at r0
    endcase
  end

endmodule

//--- logic/cpu_pkg.sv
package cpu_pkg;

  localparam int word_width = 16;
  localparam int reg_count = 8;

  typedef logic [word_width-1:0] word_t;
  typedef logic [$clog2(reg_count)-1:0] reg_addr_t;

  // instruction field positions
  localparam int opcode_msb = 15;
  localparam int opcode_lsb = 13;
  localparam int op_msb = 12;
  localparam int op_lsb = 11;
  localparam int rn_msb = 10;
  localparam int rn_lsb = 8;
  localparam int rd_msb = 7;
  localparam int rd_lsb = 5;
  localparam int shift_msb = 4;
  localparam int shift_lsb = 3;
  localparam int rm_msb = 2;
  localparam int rm_lsb = 0;
  localparam int imm8_msb = 7;
  localparam int imm8_lsb = 0;

  typedef enum logic [2:0] {
    op_alu = 3'b101,
    op_mov = 3'b110
  } opcode_t;

  typedef enum logic [1:0] {
    alu_add = 2'b00,
    alu_sub = 2'b01,
    alu_and = 2'b10,
    alu_not = 2'b11
  } alu_op_t;

  // op field values under op_mov
  localparam logic [1:0] mov_reg_op = 2'b00;
  localparam logic [1:0] mov_imm_op = 2'b10;

  typedef enum logic [1:0] {
    sh_none        = 2'b00,
    sh_left        = 2'b01,  // zero fill
    sh_right_logic = 2'b10,
    sh_right_arith = 2'b11
  } shift_op_t;

  typedef enum logic [1:0] {
    sel_rm = 2'b00,
    sel_rd = 2'b01,
    sel_rn = 2'b10
  } reg_sel_t;

  typedef enum logic {
    wb_result = 1'b0,  // register C
    wb_imm    = 1'b1   // sign extended imm8
  } wb_sel_t;

endpackage
